/* Makefile */
VERILATOR  := verilator
TOP        := tb_top
FILELIST   := rv32e_alu_core.f
FLAGS      := --binary --timing --assert -Wno-fatal
LINT_FLAGS := --lint-only --timing -Wall
OBJ_DIR    := obj_dir
PASS_MSG   := >>> PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qxF '$(PASS_MSG)'

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* decode_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv32e_macros.svh"

module decode_stage (
	input  wire                    head_valid,
	input  rv32e_pkg::fetch_pkt_t  head_pkt,
	input  rv32e_pkg::word_t       rs1_data,
	input  rv32e_pkg::word_t       rs2_data,
	input  rv32e_pkg::reg_idx_t    ex_busy_rd,
	input  wire                    ex_busy_valid,
	input  rv32e_pkg::reg_idx_t    wb_busy_rd,
	input  wire                    wb_busy_valid,
	input  wire                    advance,
	output rv32e_pkg::reg_idx_t    rs1_idx,
	output rv32e_pkg::reg_idx_t    rs2_idx,
	output logic                   pop,
	output logic                   issue_valid,
	output rv32e_pkg::ex_pkt_t     issue_pkt
);
	rv32e_pkg::inst_t inst;
	logic [6:0]       opcode;
	logic [2:0]       funct3;
	logic             funct7_5;
	rv32e_pkg::word_t imm;
	logic             use_rs1;
	logic             use_rs2;
	logic             rs1_raw;
	logic             rs2_raw;
	logic             hazard;

	assign inst     = head_pkt.inst;
	assign opcode   = inst[6:0];
	assign funct3   = inst[14:12];
	assign funct7_5 = inst[30];
	assign rs1_idx  = inst[18:15]; // Bit 4 of each field is checked below
	assign rs2_idx  = inst[23:20];

	always_comb begin
		imm                 = '0;
		use_rs1             = 1'b0;
		use_rs2             = 1'b0;
		issue_pkt.pc        = head_pkt.pc;
		issue_pkt.rd        = inst[10:7];
		issue_pkt.op_a      = rs1_data;
		issue_pkt.op_b      = rs2_data;
		issue_pkt.alu_op    = `ALU_ADD;
		issue_pkt.reg_write = 1'b1;
		issue_pkt.illegal   = inst[11]; // rd out of x0..x15
		case (opcode)
			`OPC_OP_IMM: begin
				imm              = {{20{inst[31]}}, inst[31:20]};
				use_rs1          = 1'b1;
				issue_pkt.op_b   = imm;
				issue_pkt.alu_op = {(funct3 == 3'b101) ? funct7_5 : 1'b0, funct3}; // SRAI only
				issue_pkt.illegal = inst[11] | inst[19];
			end
			`OPC_OP: begin
				use_rs1          = 1'b1;
				use_rs2          = 1'b1;
				issue_pkt.alu_op = {funct7_5, funct3};
				// funct7[5] is only defined for SUB and SRA
				issue_pkt.illegal = inst[11] | inst[19] | inst[24] |
					(funct7_5 && funct3 != 3'b000 && funct3 != 3'b101);
			end
			`OPC_LUI: begin
				imm            = {inst[31:12], 12'b0};
				issue_pkt.op_a = '0;
				issue_pkt.op_b = imm;
			end
			`OPC_AUIPC: begin
				imm            = {inst[31:12], 12'b0};
				issue_pkt.op_a = head_pkt.pc;
				issue_pkt.op_b = imm;
			end
			default: begin
				issue_pkt.illegal = 1'b1;
			end
		endcase
		if (issue_pkt.illegal) begin
			issue_pkt.reg_write = 1'b0; // Illegal retires without a write
		end
	end

	// No forwarding, wait until the producer has retired
	assign rs1_raw = use_rs1 && (|rs1_idx) &&
		((ex_busy_valid && ex_busy_rd == rs1_idx) || (wb_busy_valid && wb_busy_rd == rs1_idx));
	assign rs2_raw = use_rs2 && (|rs2_idx) &&
		((ex_busy_valid && ex_busy_rd == rs2_idx) || (wb_busy_valid && wb_busy_rd == rs2_idx));
	assign hazard  = rs1_raw || rs2_raw;

	assign issue_valid = head_valid && !hazard && advance;
	assign pop         = issue_valid;

endmodule

`default_nettype wire

/* exec_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv32e_macros.svh"

module exec_stage (
	input  wire                      clk,
	input  wire                      rst_n,
	input  wire                      advance,
	input  wire                      issue_valid,
	input  rv32e_pkg::ex_pkt_t       issue_pkt,
	output logic                     ex_valid,
	output rv32e_pkg::retire_pkt_t   ex_result,
	output rv32e_pkg::reg_idx_t      ex_busy_rd,
	output logic                     ex_busy_valid
);
	rv32e_pkg::ex_pkt_t ex_pkt;
	rv32e_pkg::word_t   result;
	logic [4:0]         shamt;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ex_valid <= 1'b0;
		end else if (advance) begin
			ex_valid <= issue_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (advance) begin
			ex_pkt <= issue_pkt;
		end
	end

	assign shamt = ex_pkt.op_b[4:0];

	always_comb begin
		case (ex_pkt.alu_op)
			`ALU_ADD:  result = ex_pkt.op_a + ex_pkt.op_b;
			`ALU_SUB:  result = ex_pkt.op_a - ex_pkt.op_b;
			`ALU_SLL:  result = ex_pkt.op_a << shamt;
			`ALU_SLT:  result = {31'b0, $signed(ex_pkt.op_a) < $signed(ex_pkt.op_b)};
			`ALU_SLTU: result = {31'b0, ex_pkt.op_a < ex_pkt.op_b};
			`ALU_XOR:  result = ex_pkt.op_a ^ ex_pkt.op_b;
			`ALU_SRL:  result = ex_pkt.op_a >> shamt;
			`ALU_SRA:  result = $signed(ex_pkt.op_a) >>> shamt;
			`ALU_OR:   result = ex_pkt.op_a | ex_pkt.op_b;
			`ALU_AND:  result = ex_pkt.op_a & ex_pkt.op_b;
			default:   result = '0; // Only reached by illegal packets
		endcase
	end

	assign ex_result     = '{ex_pkt.pc, ex_pkt.rd, result, ex_pkt.reg_write, ex_pkt.illegal};
	assign ex_busy_rd    = ex_pkt.rd;
	assign ex_busy_valid = ex_valid && ex_pkt.reg_write && (ex_pkt.rd != '0);

	// Decode only passes defined ALU codes for legal instructions
	assert property (@(posedge clk) disable iff (!rst_n)
		(ex_valid && !ex_pkt.illegal) |-> ex_pkt.alu_op inside {`ALU_ADD, `ALU_SUB,
			`ALU_SLL, `ALU_SLT, `ALU_SLTU, `ALU_XOR, `ALU_SRL, `ALU_SRA, `ALU_OR, `ALU_AND})
		else $error("exec_stage: unknown alu_op on a legal instruction");

endmodule

`default_nettype wire

/* inst_queue.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv32e_macros.svh"

module inst_queue (
	input  wire                    clk,
	input  wire                    rst_n,
	input  wire                    inst_valid,
	input  rv32e_pkg::fetch_pkt_t  inst_pkt,
	input  wire                    pop,
	output logic                   inst_credit,
	output logic                   head_valid,
	output rv32e_pkg::fetch_pkt_t  head_pkt
);
	localparam int PTR_W = $clog2(`QUEUE_DEPTH);
	localparam int CNT_W = $clog2(`QUEUE_DEPTH + 1);

	rv32e_pkg::fetch_pkt_t mem [`QUEUE_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             full;

	assign full       = (count == CNT_W'(`QUEUE_DEPTH));
	assign head_valid = (count != '0);
	assign head_pkt   = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (inst_valid) begin
			mem[wr_ptr] <= inst_pkt; // Payload, no reset
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr      <= '0;
			rd_ptr      <= '0;
			count       <= '0;
			inst_credit <= 1'b0;
		end else begin
			inst_credit <= pop; // Credit goes back one clock after the pop
			if (inst_valid) begin
				wr_ptr <= (wr_ptr == PTR_W'(`QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(`QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			count <= count + CNT_W'(inst_valid) - CNT_W'(pop);
		end
	end

	// Producer must hold a credit, so it never writes into a full queue
	assert property (@(posedge clk) disable iff (!rst_n) inst_valid |-> !full)
		else $error("inst_queue: write while full");

	// Decode pops only a valid head
	assert property (@(posedge clk) disable iff (!rst_n) pop |-> head_valid)
		else $error("inst_queue: pop while empty");

endmodule

`default_nettype wire

/* reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv32e_macros.svh"

module reg_file (
	input  wire                  clk,
	input  rv32e_pkg::reg_idx_t  rs1_idx,
	input  rv32e_pkg::reg_idx_t  rs2_idx,
	input  wire                  wr_en,
	input  rv32e_pkg::reg_idx_t  wr_idx,
	input  rv32e_pkg::word_t     wr_data,
	output rv32e_pkg::word_t     rs1_data,
	output rv32e_pkg::word_t     rs2_data
);
	rv32e_pkg::word_t regs [1:(1 << `REG_IDX_W) - 1]; // x0 has no storage

	always_ff @(posedge clk) begin
		if (wr_en && wr_idx != '0) begin
			regs[wr_idx] <= wr_data;
		end
	end

	// No write bypass, new data shows after the edge
	assign rs1_data = (rs1_idx == '0) ? '0 : regs[rs1_idx];
	assign rs2_data = (rs2_idx == '0) ? '0 : regs[rs2_idx];

endmodule

`default_nettype wire

/* retire_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv32e_macros.svh"

module retire_stage (
	input  wire                      clk,
	input  wire                      rst_n,
	input  wire                      ex_valid,
	input  rv32e_pkg::retire_pkt_t   ex_result,
	input  wire                      retire_credit,
	output logic                     advance,
	output logic                     retire_valid,
	output rv32e_pkg::retire_pkt_t   retire_pkt,
	output logic                     wr_en,
	output rv32e_pkg::reg_idx_t      wr_idx,
	output rv32e_pkg::word_t         wr_data,
	output rv32e_pkg::reg_idx_t      wb_busy_rd,
	output logic                     wb_busy_valid
);
	localparam int CNT_W = $clog2(`RETIRE_CREDITS + 1);

	logic                   wb_valid;
	rv32e_pkg::retire_pkt_t wb_pkt;
	logic [CNT_W-1:0]       credit_cnt;
	logic                   fire;

	assign fire    = wb_valid && (credit_cnt != '0);
	assign advance = !wb_valid || fire; // Whole pipe moves on this

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wb_valid   <= 1'b0;
			credit_cnt <= CNT_W'(`RETIRE_CREDITS);
		end else begin
			if (advance) begin
				wb_valid <= ex_valid;
			end
			credit_cnt <= credit_cnt - CNT_W'(fire) + CNT_W'(retire_credit);
		end
	end

	always_ff @(posedge clk) begin
		if (advance) begin
			wb_pkt <= ex_result;
		end
	end

	assign retire_valid  = fire;
	assign retire_pkt    = wb_pkt;
	assign wr_en         = fire && wb_pkt.reg_write && (wb_pkt.rd != '0);
	assign wr_idx        = wb_pkt.rd;
	assign wr_data       = wb_pkt.result;
	assign wb_busy_rd    = wb_pkt.rd;
	assign wb_busy_valid = wb_valid && wb_pkt.reg_write && (wb_pkt.rd != '0);

	// Execute holds its packet while writeback is stalled
	assert property (@(posedge clk) disable iff (!rst_n)
		(ex_valid && !advance) |=> (ex_valid && $stable(ex_result)))
		else $error("retire_stage: execute packet changed during a stall");

	// Consumer never returns more credits than it was given
	assert property (@(posedge clk) disable iff (!rst_n)
		retire_credit |-> (credit_cnt < CNT_W'(`RETIRE_CREDITS)) || retire_valid)
		else $error("retire_stage: credit counter overflow");

endmodule

`default_nettype wire

/* rv32e_alu_core.f */
+incdir+.
rv32e_pkg.sv
inst_queue.sv
decode_stage.sv
reg_file.sv
exec_stage.sv
retire_stage.sv
rv32e_alu_core.sv
tb_clock_gen.sv
tb_checker.sv
tb_top.sv

/* rv32e_alu_core.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv32e_macros.svh"

module rv32e_alu_core (
	input  wire                      clk,
	input  wire                      rst_n,
	input  wire                      inst_valid,
	input  rv32e_pkg::fetch_pkt_t    inst_pkt,
	input  wire                      retire_credit,
	output logic                     inst_credit,
	output logic                     retire_valid,
	output rv32e_pkg::retire_pkt_t   retire_pkt
);
	logic                   head_valid;
	rv32e_pkg::fetch_pkt_t  head_pkt;
	logic                   pop;
	rv32e_pkg::reg_idx_t    rs1_idx;
	rv32e_pkg::reg_idx_t    rs2_idx;
	rv32e_pkg::word_t       rs1_data;
	rv32e_pkg::word_t       rs2_data;
	logic                   issue_valid;
	rv32e_pkg::ex_pkt_t     issue_pkt;
	logic                   ex_valid;
	rv32e_pkg::retire_pkt_t ex_result;
	rv32e_pkg::reg_idx_t    ex_busy_rd;
	logic                   ex_busy_valid;
	rv32e_pkg::reg_idx_t    wb_busy_rd;
	logic                   wb_busy_valid;
	logic                   advance;
	logic                   wr_en;
	rv32e_pkg::reg_idx_t    wr_idx;
	rv32e_pkg::word_t       wr_data;

	inst_queue u_queue (
		.clk(clk), .rst_n(rst_n),
		.inst_valid(inst_valid), .inst_pkt(inst_pkt), .pop(pop),
		.inst_credit(inst_credit), .head_valid(head_valid), .head_pkt(head_pkt)
	);

	decode_stage u_decode (
		.head_valid(head_valid), .head_pkt(head_pkt),
		.rs1_data(rs1_data), .rs2_data(rs2_data),
		.ex_busy_rd(ex_busy_rd), .ex_busy_valid(ex_busy_valid),
		.wb_busy_rd(wb_busy_rd), .wb_busy_valid(wb_busy_valid),
		.advance(advance), .rs1_idx(rs1_idx), .rs2_idx(rs2_idx),
		.pop(pop), .issue_valid(issue_valid), .issue_pkt(issue_pkt)
	);

	reg_file u_regs (
		.clk(clk), .rs1_idx(rs1_idx), .rs2_idx(rs2_idx),
		.wr_en(wr_en), .wr_idx(wr_idx), .wr_data(wr_data),
		.rs1_data(rs1_data), .rs2_data(rs2_data)
	);

	exec_stage u_exec (
		.clk(clk), .rst_n(rst_n), .advance(advance),
		.issue_valid(issue_valid), .issue_pkt(issue_pkt),
		.ex_valid(ex_valid), .ex_result(ex_result),
		.ex_busy_rd(ex_busy_rd), .ex_busy_valid(ex_busy_valid)
	);

	retire_stage u_retire (
		.clk(clk), .rst_n(rst_n),
		.ex_valid(ex_valid), .ex_result(ex_result), .retire_credit(retire_credit),
		.advance(advance), .retire_valid(retire_valid), .retire_pkt(retire_pkt),
		.wr_en(wr_en), .wr_idx(wr_idx), .wr_data(wr_data),
		.wb_busy_rd(wb_busy_rd), .wb_busy_valid(wb_busy_valid)
	);

endmodule

`default_nettype wire

/* rv32e_macros.svh */
`ifndef RV32E_MACROS_SVH
`define RV32E_MACROS_SVH

`define XLEN            32
`define REG_IDX_W       4
`define QUEUE_DEPTH     4 // Also the producer's initial credits
`define RETIRE_CREDITS  4

// Supported opcodes
`define OPC_OP_IMM      7'b0010011
`define OPC_OP          7'b0110011
`define OPC_LUI         7'b0110111
`define OPC_AUIPC       7'b0010111

// ALU codes are {funct7[5], funct3}
`define ALU_ADD         4'b0000
`define ALU_SLL         4'b0001
`define ALU_SLT         4'b0010
`define ALU_SLTU        4'b0011
`define ALU_XOR         4'b0100
`define ALU_SRL         4'b0101
`define ALU_OR          4'b0110
`define ALU_AND         4'b0111
`define ALU_SUB         4'b1000
`define ALU_SRA         4'b1101

`endif

/* rv32e_pkg.sv */
`default_nettype none

`include "rv32e_macros.svh"

package rv32e_pkg;

	typedef logic [`XLEN-1:0]      word_t; // Data word or pc
	typedef logic [31:0]           inst_t;
	typedef logic [`REG_IDX_W-1:0] reg_idx_t;
	typedef logic [3:0]            alu_op_t;

	// Queue entry from the producer
	typedef struct packed {
		word_t pc;
		inst_t inst;
	} fetch_pkt_t;

	// Decode to execute
	typedef struct packed {
		word_t    pc;
		reg_idx_t rd;
		word_t    op_a;
		word_t    op_b;
		alu_op_t  alu_op;
		logic     reg_write;
		logic     illegal;
	} ex_pkt_t;

	// Execute to writeback, also the retire record
	typedef struct packed {
		word_t    pc;
		reg_idx_t rd;
		word_t    result;
		logic     reg_write;
		logic     illegal;
	} retire_pkt_t;

endpackage

`default_nettype wire

/* tb_checker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv32e_macros.svh"

module tb_checker (
	input  wire                     clk,
	input  wire                     rst_n,
	input  wire                     inst_valid,
	input  rv32e_pkg::fetch_pkt_t   inst_pkt,
	input  wire                     inst_credit,
	input  wire                     retire_valid,
	input  rv32e_pkg::retire_pkt_t  retire_pkt,
	input  wire                     retire_credit,
	output int                      mismatch_count,
	output int                      fail_count,
	output int                      accept_count,
	output int                      retire_count,
	output int                      credit_count
);
	rv32e_pkg::fetch_pkt_t log_q[$]; // Accepted, not yet retired
	rv32e_pkg::word_t      regs_model [16];
	int                    consumer_credits;

	// Unknown opcode or a register field beyond x15
	function automatic logic is_illegal(input rv32e_pkg::inst_t inst);
		case (inst[6:0])
			`OPC_OP_IMM:           return inst[11] | inst[19];
			`OPC_OP:               return inst[11] | inst[19] | inst[24];
			`OPC_LUI, `OPC_AUIPC:  return inst[11];
			default:               return 1'b1;
		endcase
	endfunction

	function automatic rv32e_pkg::word_t alu_model(input rv32e_pkg::fetch_pkt_t p);
		rv32e_pkg::inst_t inst;
		rv32e_pkg::word_t a;
		rv32e_pkg::word_t b;
		rv32e_pkg::word_t imm_u;
		logic [4:0]       shamt;
		logic             alt;
		inst  = p.inst;
		a     = regs_model[inst[18:15]];
		imm_u = {inst[31:12], 12'b0};
		if (inst[6:0] == `OPC_LUI) begin
			return imm_u;
		end else if (inst[6:0] == `OPC_AUIPC) begin
			return p.pc + imm_u;
		end
		if (inst[6:0] == `OPC_OP_IMM) begin
			b   = {{20{inst[31]}}, inst[31:20]};
			alt = inst[30] && inst[14:12] == 3'd5; // Only SRAI uses the alternate bit
		end else begin
			b   = regs_model[inst[23:20]];
			alt = inst[30];
		end
		shamt = b[4:0];
		case (inst[14:12])
			3'd0:    return alt ? a - b : a + b;
			3'd1:    return a << shamt;
			3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'd3:    return (a < b) ? 32'd1 : 32'd0;
			3'd4:    return a ^ b;
			3'd5:    return alt ? rv32e_pkg::word_t'($signed(a) >>> shamt) : a >> shamt;
			3'd6:    return a | b;
			default: return a & b;
		endcase
	endfunction

	task automatic compare_field(input string name, input rv32e_pkg::word_t exp,
		input rv32e_pkg::word_t got);
		if (exp !== got) begin
			$display("MISMATCH t=%0t %s: expected %h, got %h", $time, name, exp, got);
			mismatch_count++;
		end
	endtask

	task automatic check_retire();
		rv32e_pkg::fetch_pkt_t p;
		rv32e_pkg::word_t      exp_result;
		logic                  ill;
		logic [3:0]            rd;
		if (log_q.size() == 0) begin
			$display("ERROR t=%0t: retire record with no outstanding instruction", $time);
			fail_count++;
		end else begin
			p   = log_q.pop_front(); // Oldest first, so order is checked too
			ill = is_illegal(p.inst);
			rd  = p.inst[10:7];
			compare_field("pc", p.pc, retire_pkt.pc);
			compare_field("rd", 32'(rd), 32'(retire_pkt.rd));
			compare_field("reg_write", 32'(!ill), 32'(retire_pkt.reg_write));
			compare_field("illegal", 32'(ill), 32'(retire_pkt.illegal));
			if (!ill) begin
				exp_result = alu_model(p);
				compare_field("result", exp_result, retire_pkt.result);
				if (rd != 4'd0) begin
					regs_model[rd] = exp_result; // x0 stays zero
				end
			end
		end
	endtask

	always @(posedge clk) begin
		if (!rst_n) begin
			log_q.delete();
			foreach (regs_model[k]) begin
				regs_model[k] = '0;
			end
			consumer_credits = `RETIRE_CREDITS;
			mismatch_count   = 0;
			fail_count       = 0;
			accept_count     = 0;
			retire_count     = 0;
			credit_count     = 0;
		end else begin
			if (inst_valid) begin
				log_q.push_back(inst_pkt);
				accept_count++;
			end
			if (inst_credit) begin
				credit_count++;
			end
			if (retire_valid) begin
				if (consumer_credits == 0) begin
					$display("ERROR t=%0t: retire with no credit from the consumer", $time);
					fail_count++;
				end
				check_retire();
				retire_count++;
			end
			consumer_credits = consumer_credits - int'(retire_valid) + int'(retire_credit);
		end
	end

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
	output logic clk,
	output logic rst_n
);
	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk; // 40 ns period
	end

	initial begin
		rst_n = 1'b0;
		repeat (16) @(posedge clk);
		@(negedge clk); // Released on the falling edge like the other inputs
		rst_n = 1'b1;
	end

endmodule

`default_nettype wire

/* tb_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv32e_macros.svh"

module tb_top;
	localparam int NUM_INST       = 400;
	localparam int TIMEOUT_CYCLES = NUM_INST * 12 + 200;

	logic                   clk;
	logic                   rst_n;
	logic                   inst_valid;
	rv32e_pkg::fetch_pkt_t  inst_pkt;
	logic                   inst_credit;
	logic                   retire_credit;
	logic                   retire_valid;
	rv32e_pkg::retire_pkt_t retire_pkt;
	int                     mismatch_count;
	int                     fail_count;
	int                     accept_count;
	int                     retire_count;
	int                     credit_count;
	int                     tb_errors = 0;
	int                     cycle_count = 0;

	tb_clock_gen clk_gen0 (.clk(clk), .rst_n(rst_n));

	rv32e_alu_core dut0 (
		.clk(clk), .rst_n(rst_n),
		.inst_valid(inst_valid), .inst_pkt(inst_pkt), .retire_credit(retire_credit),
		.inst_credit(inst_credit), .retire_valid(retire_valid), .retire_pkt(retire_pkt)
	);

	tb_checker chk0 (
		.clk(clk), .rst_n(rst_n),
		.inst_valid(inst_valid), .inst_pkt(inst_pkt), .inst_credit(inst_credit),
		.retire_valid(retire_valid), .retire_pkt(retire_pkt), .retire_credit(retire_credit),
		.mismatch_count(mismatch_count), .fail_count(fail_count),
		.accept_count(accept_count), .retire_count(retire_count),
		.credit_count(credit_count)
	);

	// Mostly x0..x3 so that hazards are frequent
	function automatic logic [3:0] pick_reg();
		if ($urandom_range(0, 9) < 8) begin
			return 4'($urandom_range(0, 3));
		end else begin
			return 4'($urandom_range(0, 15));
		end
	endfunction

	function automatic logic [6:0] bad_opcode();
		case ($urandom_range(0, 4))
			0:       return 7'b0000011; // Load
			1:       return 7'b0100011; // Store
			2:       return 7'b1100011; // Branch
			3:       return 7'b1101111; // JAL
			default: return 7'b1110011; // System
		endcase
	endfunction

	function automatic rv32e_pkg::inst_t make_inst(input int idx);
		rv32e_pkg::inst_t inst;
		logic [3:0]       rd;
		logic [3:0]       rs1;
		logic [3:0]       rs2;
		logic [2:0]       f3;
		logic [6:0]       f7;
		int               kind;
		rd   = pick_reg();
		rs1  = pick_reg();
		rs2  = pick_reg();
		f3   = 3'($urandom_range(0, 7));
		f7   = ((f3 == 3'd0 || f3 == 3'd5) && $urandom_range(0, 1) == 1) ? 7'h20 : 7'h00;
		kind = $urandom_range(0, 99);
		if (idx < 15) begin
			inst = {20'($urandom), 1'b0, 4'(idx + 1), `OPC_LUI}; // Give x1..x15 known values
		end else if (kind < 40) begin
			inst = {12'($urandom), 1'b0, rs1, f3, 1'b0, rd, `OPC_OP_IMM};
			if (f3 == 3'd1 || f3 == 3'd5) begin
				inst[31:25] = (f3 == 3'd5) ? f7 : 7'h00; // SLLI, SRLI or SRAI
			end
		end else if (kind < 75) begin
			inst = {f7, 1'b0, rs2, 1'b0, rs1, f3, 1'b0, rd, `OPC_OP};
		end else if (kind < 83) begin
			inst = {20'($urandom), 1'b0, rd, `OPC_LUI};
		end else if (kind < 90) begin
			inst = {20'($urandom), 1'b0, rd, `OPC_AUIPC};
		end else begin
			inst = {f7, 1'b0, rs2, 1'b0, rs1, f3, 1'b0, rd, `OPC_OP};
			case ($urandom_range(0, 3))
				0:       inst[6:0] = bad_opcode();
				1:       inst[11] = 1'b1; // rd above x15
				2:       inst[19] = 1'b1; // rs1 above x15
				default: inst[24] = 1'b1; // rs2 above x15
			endcase
		end
		return inst;
	endfunction

	task automatic report_and_finish(input bit timed_out);
		int total;
		total = mismatch_count + fail_count + tb_errors;
		$display("Errors: %0d mismatches, %0d other, %0d testbench; %0d of %0d retired",
			mismatch_count, fail_count, tb_errors, retire_count, NUM_INST);
		if (timed_out || total != 0) begin
			$display(">>> FAIL");
		end else begin
			$display(">>> PASS");
		end
		$finish;
	endtask

	always @(posedge clk) begin
		if (rst_n) begin
			cycle_count = cycle_count + 1;
		end
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("ERROR: timeout after %0d cycles, %0d of %0d instructions retired",
				cycle_count, retire_count, NUM_INST);
			report_and_finish(1'b1);
		end
	end

	// Producer side
	initial begin : producer
		int               credits;
		int               sent;
		rv32e_pkg::word_t pc;
		void'($urandom(32'hb4aa));
		credits    = `QUEUE_DEPTH;
		sent       = 0;
		pc         = 32'h0000_1000;
		inst_valid = 1'b0;
		inst_pkt   = '0;
		@(posedge rst_n);
		while (retire_count < NUM_INST) begin
			@(negedge clk);
			credits += int'(inst_credit); // Pulse lasts one full cycle
			if (credits > `QUEUE_DEPTH) begin
				$display("ERROR t=%0t: producer holds %0d credits, more than the queue depth",
					$time, credits);
				tb_errors++;
			end
			if (sent < NUM_INST && credits > 0 && $urandom_range(0, 3) != 0) begin
				inst_valid    = 1'b1;
				inst_pkt.pc   = pc;
				inst_pkt.inst = make_inst(sent);
				pc            = pc + 32'd4;
				credits--;
				sent++;
			end else begin
				inst_valid = 1'b0;
			end
		end
		inst_valid = 1'b0;
		repeat (10) @(negedge clk); // Room for a stray extra retire
		if (accept_count != NUM_INST) begin
			$display("ERROR: %0d of %0d instructions were accepted", accept_count, NUM_INST);
			tb_errors++;
		end
		if (retire_count != accept_count) begin
			$display("ERROR: %0d retire records for %0d accepted instructions",
				retire_count, accept_count);
			tb_errors++;
		end
		if (credit_count != accept_count) begin
			$display("ERROR: %0d queue credits returned for %0d accepted instructions",
				credit_count, accept_count);
			tb_errors++;
		end
		report_and_finish(1'b0);
	end

	// Consumer side, one credit back per record after 0 to 6 cycles
	initial begin : consumer
		int due_q[$];
		int found;
		int k;
		retire_credit = 1'b0;
		@(posedge rst_n);
		forever begin
			@(negedge clk);
			retire_credit = 1'b0;
			if (retire_valid) begin
				due_q.push_back(cycle_count + 1 + int'($urandom_range(0, 6)));
			end
			found = -1;
			for (k = 0; k < due_q.size(); k++) begin
				if (found < 0 && due_q[k] <= cycle_count) begin
					found = k;
				end
			end
			if (found >= 0) begin
				due_q.delete(found);
				retire_credit = 1'b1;
			end
		end
	end

endmodule

`default_nettype wire
